// ==== Makefile ====
# Verilator build and run for the free-object cache

VERILATOR ?= verilator
TOP ?= tbFreeObjectCache
RTL_TOP ?= freeObjectCache
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 4
VFLAGS ?= --timing --assert --timescale 1ns/10ps
FAIL_MSG ?= ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/fc_consts.svh ====
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// --------------------------------------------------------------------------
// table geometry
// --------------------------------------------------------------------------

// index width for the free-object table
`define FC_INDEX_W 8
// total table entries
`define FC_ENTRIES 256
// descriptor entries sit below this index
// objects sit at and above it
`define FC_REGION 128

// --------------------------------------------------------------------------
// field widths
// --------------------------------------------------------------------------

`define FC_SEL_W 24
`define FC_LEN_W 32
// byte totals need headroom above a single length
`define FC_MEM_W 40

`endif

// ==== source/entryRam.sv ====
`timescale 1ns/10ps
`include "fc_consts.svh"

module entryRam (
	input logic CLK,
	input logic [`FC_INDEX_W-1:0] addr,
	input logic we,
	input logic [`FC_SEL_W-1:0] wrSel,
	input logic [`FC_LEN_W-1:0] wrLength,
	output logic [`FC_SEL_W-1:0] rdSel,
	output logic [`FC_LEN_W-1:0] rdLength
);

	// selector in the upper bits, length in the lower bits
	logic [`FC_SEL_W+`FC_LEN_W-1:0] mem [`FC_ENTRIES];

	// --------------------------------------------------------------------------
	// single port, registered read
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= {wrSel, wrLength};
		end
	end

	// read returns the old contents on a write cycle
	always_ff @(posedge CLK) begin
		rdSel <= mem[addr][`FC_SEL_W+`FC_LEN_W-1:`FC_LEN_W];
		rdLength <= mem[addr][`FC_LEN_W-1:0];
	end

endmodule

// ==== source/fcCmdPkg.sv ====
package fcCmdPkg;

	// opcodes accepted on the command port
	typedef enum logic [3:0] {
		opWrite,
		opClear,
		opFreeObj,
		opFreeEntry,
		opFit,
		opUsedEntry,
		opCalc,
		opMemAdd,
		opMemSub,
		opMemReset
	} cacheOp;

	// tag carried along with each scan address
	typedef enum logic [2:0] {
		scanNone,
		scanClear,
		scanFree,
		scanFit,
		scanUsed,
		scanCalc
	} scanKind;

endpackage

// ==== source/fcTablePkg.sv ====
`include "fc_consts.svh"

package fcTablePkg;

	// entry index into the free-object table
	typedef logic [`FC_INDEX_W-1:0] tableIndex;

	// object selector
	// zero selector marks a free slot
	typedef logic [`FC_SEL_W-1:0] selector;

	// object length in bytes
	typedef logic [`FC_LEN_W-1:0] objLength;

	// running byte totals
	// wide enough to sum a full object region
	typedef logic [`FC_MEM_W-1:0] memTotal;

endpackage

// ==== source/freeObjectCache.sv ====
`timescale 1ns/10ps

module freeObjectCache
	import fcTablePkg::*;
	import fcCmdPkg::*;
(
	input logic CLK,
	input logic RESETn,
	// command port
	input logic cmdValid,
	input cacheOp cmdOp,
	input tableIndex cmdIndex,
	input selector cmdSel,
	input objLength cmdLength,
	output logic cmdReady,
	// result port
	output logic resValid,
	output logic resFound,
	output tableIndex resIndex,
	output selector resSel,
	output objLength resLength,
	input logic resReady,
	// memory totals
	output memTotal freeMem,
	output memTotal cachedMem
);

	// sequencer to evaluator
	logic scanStart;
	objLength fitLength;
	logic issueValid;
	scanKind issueKind;
	tableIndex issueIndex;
	logic hit;

	// table RAM
	tableIndex ramAddr;
	logic ramWe;
	selector ramSel;
	objLength ramLength;
	selector rdSel;
	objLength rdLength;

	// free-space counter
	logic memCmdValid;
	cacheOp memOp;
	objLength memLength;

	scanSequencer u_seq (
		.CLK(CLK), .RESETn(RESETn),
		.cmdValid(cmdValid), .cmdOp(cmdOp), .cmdIndex(cmdIndex),
		.cmdSel(cmdSel), .cmdLength(cmdLength), .cmdReady(cmdReady),
		.resReady(resReady), .resValid(resValid),
		.hit(hit), .scanStart(scanStart), .fitLength(fitLength),
		.ramAddr(ramAddr), .ramWe(ramWe), .ramSel(ramSel), .ramLength(ramLength),
		.issueValid(issueValid), .issueKind(issueKind), .issueIndex(issueIndex),
		.memCmdValid(memCmdValid), .memOp(memOp), .memLength(memLength)
	);

	entryRam u_ram (
		.CLK(CLK), .addr(ramAddr), .we(ramWe),
		.wrSel(ramSel), .wrLength(ramLength),
		.rdSel(rdSel), .rdLength(rdLength)
	);

	matchEvaluator u_eval (
		.CLK(CLK), .RESETn(RESETn),
		.scanStart(scanStart), .fitLength(fitLength),
		.issueValid(issueValid), .issueKind(issueKind), .issueIndex(issueIndex),
		.rdSel(rdSel), .rdLength(rdLength),
		.hit(hit), .resFound(resFound), .resIndex(resIndex),
		.resSel(resSel), .resLength(resLength), .cachedMem(cachedMem)
	);

	freeSpaceCounter u_free (
		.CLK(CLK), .RESETn(RESETn),
		.memCmdValid(memCmdValid), .memOp(memOp), .memLength(memLength),
		.freeMem(freeMem)
	);

endmodule

// ==== source/freeSpaceCounter.sv ====
`timescale 1ns/10ps

module freeSpaceCounter
	import fcTablePkg::*;
	import fcCmdPkg::*;
(
	input logic CLK,
	input logic RESETn,
	input logic memCmdValid,
	input cacheOp memOp,
	input objLength memLength,
	output memTotal freeMem
);

	// --------------------------------------------------------------------------
	// free-memory accumulator
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			freeMem <= '0;
		end else if (memCmdValid) begin
			case (memOp)
				opMemAdd: freeMem <= freeMem + memTotal'(memLength);
				// release frees the length plus one byte
				opMemSub: freeMem <= freeMem - memTotal'(memLength) - memTotal'(1);
				opMemReset: freeMem <= '0;
				default: freeMem <= freeMem;
			endcase
		end
	end

	// wraps modulo 2^40 by width

endmodule

// ==== source/matchEvaluator.sv ====
`timescale 1ns/10ps

module matchEvaluator
	import fcTablePkg::*;
	import fcCmdPkg::*;
(
	input logic CLK,
	input logic RESETn,
	input logic scanStart,
	input objLength fitLength,
	// tagged address stream
	input logic issueValid,
	input scanKind issueKind,
	input tableIndex issueIndex,
	// RAM read data
	input selector rdSel,
	input objLength rdLength,
	output logic hit,
	// found entry
	output logic resFound,
	output tableIndex resIndex,
	output selector resSel,
	output objLength resLength,
	output memTotal cachedMem
);

	logic tagValid;
	scanKind tagKind;
	tableIndex tagIndex;
	logic match;

	// tag delayed one cycle to meet the RAM data
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			tagValid <= 1'b0;
			tagKind <= scanNone;
		end else begin
			tagValid <= issueValid;
			tagKind <= issueKind;
		end
	end

	always_ff @(posedge CLK) begin
		tagIndex <= issueIndex;
	end

	// --------------------------------------------------------------------------
	// scan rules
	// --------------------------------------------------------------------------
	always_comb begin
		case (tagKind)
			scanFree: match = (rdSel == '0);
			scanFit: match = (rdLength >= fitLength);
			scanUsed: match = (rdSel != '0);
			// clear and calc never stop early
			default: match = 1'b0;
		endcase
	end

	// only the first match counts
	assign hit = tagValid & match & ~resFound;

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			resFound <= 1'b0;
			cachedMem <= '0;
		end else begin
			if (scanStart) begin
				resFound <= 1'b0;
			end else if (hit) begin
				resFound <= 1'b1;
			end
			// sum restarts only for calc scans
			if (scanStart && issueKind == scanCalc) begin
				cachedMem <= '0;
			end else if (tagValid && tagKind == scanCalc) begin
				cachedMem <= cachedMem + memTotal'(rdLength);
			end
		end
	end

	// found entry capture
	always_ff @(posedge CLK) begin
		if (hit) begin
			resIndex <= tagIndex;
			resSel <= rdSel;
			resLength <= rdLength;
		end
	end

endmodule

// ==== source/scanSequencer.sv ====
`timescale 1ns/10ps
`include "fc_consts.svh"

module scanSequencer
	import fcTablePkg::*;
	import fcCmdPkg::*;
(
	input logic CLK,
	input logic RESETn,
	// command port
	input logic cmdValid,
	input cacheOp cmdOp,
	input tableIndex cmdIndex,
	input selector cmdSel,
	input objLength cmdLength,
	output logic cmdReady,
	// result handshake
	input logic resReady,
	output logic resValid,
	// evaluator control
	input logic hit,
	output logic scanStart,
	output objLength fitLength,
	// table RAM
	output tableIndex ramAddr,
	output logic ramWe,
	output selector ramSel,
	output objLength ramLength,
	// tagged address stream
	output logic issueValid,
	output scanKind issueKind,
	output tableIndex issueIndex,
	// free-space counter
	output logic memCmdValid,
	output cacheOp memOp,
	output objLength memLength
);

	typedef enum logic [1:0] {stIdle, stScan, stDrain, stReport} seqState;

	seqState state;
	tableIndex endAddr;
	logic evalPending;
	logic [1:0] inFlight;
	logic accept;
	logic scanOp;
	scanKind startKind;
	tableIndex startAddr;
	tableIndex lastAddr;

	assign accept = cmdValid & cmdReady;
	// evaluator tag follows the RAM address
	assign issueIndex = ramAddr;
	// one address in the RAM, one in the evaluator
	assign inFlight = {1'b0, issueValid} + {1'b0, evalPending};

	// --------------------------------------------------------------------------
	// region and tag per scan opcode
	// --------------------------------------------------------------------------
	always_comb begin
		scanOp = 1'b1;
		startKind = scanNone;
		startAddr = tableIndex'(`FC_REGION);
		lastAddr = tableIndex'(`FC_ENTRIES - 1);
		case (cmdOp)
			opClear: begin
				startKind = scanClear;
				startAddr = '0;
			end
			opFreeObj: startKind = scanFree;
			opFreeEntry: begin
				startKind = scanFree;
				startAddr = '0;
				lastAddr = tableIndex'(`FC_REGION - 1);
			end
			opFit: startKind = scanFit;
			opUsedEntry: begin
				startKind = scanUsed;
				startAddr = '0;
				lastAddr = tableIndex'(`FC_REGION - 1);
			end
			opCalc: startKind = scanCalc;
			// write and free-memory ops
			default: scanOp = 1'b0;
		endcase
	end

	// --------------------------------------------------------------------------
	// control FSM and address counter
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= stIdle;
			cmdReady <= 1'b0;
			resValid <= 1'b0;
			scanStart <= 1'b0;
			ramWe <= 1'b0;
			ramAddr <= '0;
			issueValid <= 1'b0;
			issueKind <= scanNone;
			evalPending <= 1'b0;
			memCmdValid <= 1'b0;
		end else begin
			scanStart <= 1'b0;
			memCmdValid <= 1'b0;
			evalPending <= issueValid;
			case (state)
				stIdle: begin
					cmdReady <= 1'b1;
					ramWe <= 1'b0;
					if (accept && scanOp) begin
						state <= stScan;
						cmdReady <= 1'b0;
						scanStart <= 1'b1;
						issueValid <= 1'b1;
						issueKind <= startKind;
						ramAddr <= startAddr;
						// clear writes zero on every scan step
						ramWe <= (startKind == scanClear);
					end else if (accept && cmdOp == opWrite) begin
						ramWe <= 1'b1;
						ramAddr <= cmdIndex;
					end else if (accept) begin
						memCmdValid <= 1'b1;
					end
				end
				stScan: begin
					if (hit || ramAddr == endAddr) begin
						// stop issuing, anything behind a hit is dropped
						state <= hit ? stReport : stDrain;
						resValid <= hit;
						issueValid <= 1'b0;
						issueKind <= scanNone;
						ramWe <= 1'b0;
					end else begin
						ramAddr <= ramAddr + tableIndex'(1);
					end
				end
				stDrain: begin
					// wait for the last address to leave the evaluator
					if (hit || inFlight == 2'd0) begin
						state <= stReport;
						resValid <= 1'b1;
					end
				end
				stReport: begin
					if (resReady) begin
						state <= stIdle;
						resValid <= 1'b0;
						cmdReady <= 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// payload latched on acceptance
	always_ff @(posedge CLK) begin
		if (accept) begin
			fitLength <= cmdLength;
			endAddr <= lastAddr;
			// zero data for clear scans
			ramSel <= scanOp ? '0 : cmdSel;
			ramLength <= scanOp ? '0 : cmdLength;
			memOp <= cmdOp;
			memLength <= cmdLength;
		end
	end

endmodule

// ==== tb.f ====
+incdir+include
source/fcTablePkg.sv
source/fcCmdPkg.sv
source/entryRam.sv
source/matchEvaluator.sv
source/freeSpaceCounter.sv
source/scanSequencer.sv
source/freeObjectCache.sv
test/fc_assertions.sv
test/tbFreeObjectCache.sv

// ==== test/fc_assertions.sv ====
`timescale 1ns/10ps

module fc_assertions
	import fcTablePkg::*;
	import fcCmdPkg::*;
(
	input logic CLK,
	input logic RESETn,
	input logic cmdValid,
	input cacheOp cmdOp,
	input tableIndex cmdIndex,
	input selector cmdSel,
	input objLength cmdLength,
	input logic cmdReady,
	input logic resValid,
	input logic resFound,
	input tableIndex resIndex,
	input selector resSel,
	input objLength resLength,
	input logic resReady
);

	// --------------------------------------------------------------------------
	// command port
	// --------------------------------------------------------------------------

	// stalled command keeps its payload
	assert property (@(posedge CLK) disable iff (!RESETn)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmdOp) && $stable(cmdIndex)
			&& $stable(cmdSel) && $stable(cmdLength))
	else $error("command inputs changed while stalled");

	// --------------------------------------------------------------------------
	// result port
	// --------------------------------------------------------------------------

	// held result under back-pressure
	assert property (@(posedge CLK) disable iff (!RESETn)
		resValid && !resReady |=> resValid && $stable(resFound) && $stable(resIndex)
			&& $stable(resSel) && $stable(resLength))
	else $error("result changed under back-pressure");

	// no new command while a result waits
	assert property (@(posedge CLK) disable iff (!RESETn) !(cmdReady && resValid))
	else $error("cmdReady and resValid high together");

endmodule

bind freeObjectCache fc_assertions u_handshakeChecks (
	.CLK(CLK), .RESETn(RESETn),
	.cmdValid(cmdValid), .cmdOp(cmdOp), .cmdIndex(cmdIndex),
	.cmdSel(cmdSel), .cmdLength(cmdLength), .cmdReady(cmdReady),
	.resValid(resValid), .resFound(resFound), .resIndex(resIndex),
	.resSel(resSel), .resLength(resLength), .resReady(resReady)
);

// ==== test/tbFreeObjectCache.sv ====
`timescale 1ns/10ps
`include "fc_consts.svh"

module tbFreeObjectCache
	import fcTablePkg::*;
	import fcCmdPkg::*;
();

	// cycles any single wait may take
	localparam int TIMEOUT = 2000;

	logic CLK;
	logic RESETn;
	logic cmdValid;
	cacheOp cmdOp;
	tableIndex cmdIndex;
	selector cmdSel;
	objLength cmdLength;
	logic cmdReady;
	logic resValid;
	logic resFound;
	tableIndex resIndex;
	selector resSel;
	objLength resLength;
	logic resReady;
	memTotal freeMem;
	memTotal cachedMem;

	// reference copy of the table and of the free total
	selector modelSel [`FC_ENTRIES];
	objLength modelLen [`FC_ENTRIES];
	memTotal modelFree;

	// expected scan results, oldest first
	cacheOp expOpQ [$];
	logic expFoundQ [$];
	tableIndex expIndexQ [$];
	selector expSelQ [$];
	objLength expLenQ [$];
	memTotal expSumQ [$];

	logic [31:0] lfsrState;
	int checkCount;
	int errorCount;
	int testStartErrors;

	freeObjectCache i_dut (.*);

	// 8 ns period
	always #4 CLK = ~CLK;

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hD0000001) : (lfsrState >> 1);
		end
		return value;
	endfunction

	// first match in the region, or the region sum for calc
	function automatic void expectScan(input cacheOp op, input objLength fitLen,
			output logic found, output tableIndex index, output selector sel,
			output objLength len, output memTotal sum);
		int first;
		int last;
		tableIndex at;
		logic match;
		found = 1'b0;
		index = '0;
		sel = '0;
		len = '0;
		sum = '0;
		// entry region sits low, object region high
		first = (op == opFreeEntry || op == opUsedEntry) ? 0 : `FC_REGION;
		last = (first == 0) ? `FC_REGION - 1 : `FC_ENTRIES - 1;
		for (int i = first; i <= last; i++) begin
			at = tableIndex'(i);
			case (op)
				opFreeObj, opFreeEntry: match = (modelSel[at] == '0);
				opFit: match = (modelLen[at] >= fitLen);
				opUsedEntry: match = (modelSel[at] != '0);
				default: match = 1'b0;
			endcase
			if (op == opCalc) begin
				sum = sum + memTotal'(modelLen[at]);
			end
			if (match && !found) begin
				found = 1'b1;
				index = at;
				sel = modelSel[at];
				len = modelLen[at];
			end
		end
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// holds cmdValid until the DUT takes the command
	task automatic waitAccept();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!cmdReady && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!cmdReady) abortOnTimeout("command was never accepted");
		@(posedge CLK);
		#1;
		cmdValid = 1'b0;
	endtask

	task automatic sendCommand(input cacheOp op, input tableIndex index,
			input selector sel, input objLength len);
		cmdValid = 1'b1;
		cmdOp = op;
		cmdIndex = index;
		cmdSel = sel;
		cmdLength = len;
		waitAccept();
	endtask

	task automatic writeEntry(input tableIndex index, input selector sel,
			input objLength len);
		modelSel[index] = sel;
		modelLen[index] = len;
		sendCommand(opWrite, index, sel, len);
	endtask

	// expectation goes into the queues before the command
	task automatic queueScan(input cacheOp op, input objLength fitLen);
		logic found;
		tableIndex index;
		selector sel;
		objLength len;
		memTotal sum;
		expectScan(op, fitLen, found, index, sel, len, sum);
		expOpQ.push_back(op);
		expFoundQ.push_back(found);
		expIndexQ.push_back(index);
		expSelQ.push_back(sel);
		expLenQ.push_back(len);
		expSumQ.push_back(sum);
		if (op == opClear) begin
			foreach (modelSel[i]) begin
				modelSel[i] = '0;
				modelLen[i] = '0;
			end
		end
		sendCommand(op, '0, '0, fitLen);
	endtask

	// result taken on the edge after resValid is seen
	task automatic waitResult();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!resValid && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!resValid) abortOnTimeout("scan never returned a result");
		@(posedge CLK);
		#1;
	endtask

	task automatic runScan(input cacheOp op, input objLength fitLen);
		queueScan(op, fitLen);
		waitResult();
	endtask

	task automatic memCommand(input cacheOp op, input objLength len);
		case (op)
			opMemAdd: modelFree = modelFree + memTotal'(len);
			// release frees one byte more than the length
			opMemSub: modelFree = modelFree - memTotal'(len) - memTotal'(1);
			default: modelFree = '0;
		endcase
		sendCommand(op, '0, '0, len);
		repeat (2) @(posedge CLK);
		#1;
		checkValue("freeMem", 64'(freeMem), 64'(modelFree));
	endtask

	// result held back while a memory command waits behind it
	task automatic stallResult(input objLength addLen);
		int cycles;
		int stall;
		logic heldFound;
		tableIndex heldIndex;
		selector heldSel;
		objLength heldLen;
		resReady = 1'b0;
		queueScan(opFit, objLength'(1));
		cycles = 0;
		@(negedge CLK);
		while (!resValid && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!resValid) abortOnTimeout("stalled scan never returned a result");
		heldFound = resFound;
		heldIndex = resIndex;
		heldSel = resSel;
		heldLen = resLength;
		@(posedge CLK);
		#1;
		cmdValid = 1'b1;
		cmdOp = opMemAdd;
		cmdLength = addLen;
		stall = 3 + randBits(4);
		repeat (stall) begin
			@(negedge CLK);
			checkValue("resValid", 64'(resValid), 64'(1'b1));
			checkValue("resFound", 64'(resFound), 64'(heldFound));
			checkValue("resIndex", 64'(resIndex), 64'(heldIndex));
			checkValue("resSel", 64'(resSel), 64'(heldSel));
			checkValue("resLength", 64'(resLength), 64'(heldLen));
			checkValue("cmdReady", 64'(cmdReady), 64'(1'b0));
			checkValue("freeMem", 64'(freeMem), 64'(modelFree));
		end
		@(posedge CLK);
		#1;
		resReady = 1'b1;
		modelFree = modelFree + memTotal'(addLen);
		waitAccept();
		repeat (2) @(posedge CLK);
		#1;
		checkValue("freeMem", 64'(freeMem), 64'(modelFree));
	endtask

	task automatic markTestStart();
		testStartErrors = errorCount;
	endtask

	task automatic reportTest(input string name);
		if (errorCount == testStartErrors) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed, %0d bad checks", name, errorCount - testStartErrors);
		end
	endtask

	// --------------------------------------------------------------------------
	// result comparison
	// --------------------------------------------------------------------------
	always @(negedge CLK) begin : compareResults
		cacheOp op;
		logic found;
		memTotal sum;
		if (RESETn && resValid && resReady) begin
			assert (expOpQ.size() != 0) else begin
				errorCount++;
				$display("result returned at %0t ns with no scan outstanding", $time);
			end
			if (expOpQ.size() != 0) begin
				op = expOpQ.pop_front();
				found = expFoundQ.pop_front();
				sum = expSumQ.pop_front();
				checkValue("resFound", 64'(resFound), 64'(found));
				if (found) begin
					checkValue("resIndex", 64'(resIndex), 64'(expIndexQ[0]));
					checkValue("resSel", 64'(resSel), 64'(expSelQ[0]));
					checkValue("resLength", 64'(resLength), 64'(expLenQ[0]));
				end
				void'(expIndexQ.pop_front());
				void'(expSelQ.pop_front());
				void'(expLenQ.pop_front());
				if (op == opCalc) begin
					checkValue("cachedMem", 64'(cachedMem), 64'(sum));
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------
	initial begin : mainSequence
		logic [31:0] pick;
		CLK = 1'b0;
		RESETn = 1'b0;
		cmdValid = 1'b0;
		cmdOp = opWrite;
		cmdIndex = '0;
		cmdSel = '0;
		cmdLength = '0;
		resReady = 1'b1;
		lfsrState = 32'h53082024;
		modelFree = '0;
		checkCount = 0;
		errorCount = 0;
		testStartErrors = 0;
		repeat (8) @(posedge CLK);
		#1;
		RESETn = 1'b1;

		markTestStart();
		// still held from reset
		checkValue("cmdReady", 64'(cmdReady), 64'(1'b0));
		checkValue("freeMem", 64'(freeMem), 64'(0));
		checkValue("cachedMem", 64'(cachedMem), 64'(0));
		@(posedge CLK);
		#1;
		checkValue("cmdReady", 64'(cmdReady), 64'(1'b1));
		checkValue("resValid", 64'(resValid), 64'(1'b0));
		reportTest("reset");

		// first fitting object, lengths kept short so some fit
		markTestStart();
		runScan(opClear, '0);
		for (int k = 0; k < 24; k++) begin
			writeEntry(tableIndex'(`FC_REGION + randBits(7)), selector'(randBits(24)),
				objLength'(randBits(16)));
		end
		for (int k = 0; k < 6; k++) begin
			runScan(opFit, objLength'(randBits(16)));
		end
		runScan(opFit, 32'hFFFFFFFF);
		reportTest("fit");

		// free slot search, then with both regions full
		markTestStart();
		runScan(opFreeObj, '0);
		runScan(opFreeEntry, '0);
		for (int k = 0; k < 40; k++) begin
			writeEntry(tableIndex'(randBits(6)), selector'(randBits(24)) | selector'(1),
				objLength'(randBits(32)));
		end
		runScan(opFreeEntry, '0);
		runScan(opFreeObj, '0);
		for (int i = 0; i < `FC_ENTRIES; i++) begin
			writeEntry(tableIndex'(i), selector'(randBits(24)) | selector'(1),
				objLength'(randBits(32)));
		end
		runScan(opFreeObj, '0);
		runScan(opFreeEntry, '0);
		reportTest("free");

		// used descriptor entry
		markTestStart();
		runScan(opUsedEntry, '0);
		runScan(opClear, '0);
		for (int k = 0; k < 4; k++) begin
			writeEntry(tableIndex'(32 + randBits(6)), selector'(randBits(24)) | selector'(1),
				objLength'(randBits(32)));
		end
		runScan(opUsedEntry, '0);
		runScan(opClear, '0);
		runScan(opUsedEntry, '0);
		reportTest("used");

		// cached total over the object region
		markTestStart();
		runScan(opCalc, '0);
		for (int k = 0; k < 48; k++) begin
			writeEntry(tableIndex'(`FC_REGION + randBits(7)), selector'(randBits(24)),
				objLength'(randBits(32)));
		end
		runScan(opCalc, '0);
		// second pass over the same table, sum must restart
		runScan(opCalc, '0);
		reportTest("calc");

		// free-memory counter
		markTestStart();
		for (int k = 0; k < 24; k++) begin
			pick = randBits(2);
			if (pick == 3) begin
				memCommand(opMemReset, '0);
			end else if (pick == 2) begin
				memCommand(opMemSub, objLength'(randBits(32)));
			end else begin
				memCommand(opMemAdd, objLength'(randBits(32)));
			end
		end
		reportTest("freemem");

		// result back-pressure
		markTestStart();
		writeEntry(tableIndex'(`FC_REGION + 5), selector'(24'h00A5A5), objLength'(32'h1000));
		stallResult(objLength'(randBits(20)));
		stallResult(objLength'(randBits(20)));
		reportTest("backpressure");

		assert (expOpQ.size() == 0) else begin
			errorCount++;
			$display("%0d scan results never arrived", expOpQ.size());
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
